// ==== list.f ====
+incdir+source
source/axi_pkg.sv
source/apb_pkg.sv
source/axi_request_decode.sv
source/apb_access_engine.sv
source/axi_response_path.sv
source/axi_apb_bridge.sv
test/tb_apb_slave_model.sv
test/tb_axi_apb_bridge.sv

// ==== source/apb_access_engine.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module apb_access_engine
    import apb_pkg::*;
(
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  apb_beat_t                 beat,
    input  logic                      beat_valid,
    output logic                      beat_ready,
    input  logic                      resp_free,
    output apb_req_t                  apb_req,
    output apb_sel_t                  psel,
    output logic                      penable,
    input  logic [`BRIDGE_DATA_W-1:0] prdata,
    input  logic                      pready,
    output logic                      done,
    output logic [`BRIDGE_DATA_W-1:0] done_data,
    output logic                      done_last,
    output logic                      done_err
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS
    } apb_state_t;

    apb_state_t state;
    apb_beat_t  beat_q;
    logic       take;

    // Hold off while the result stage is busy or about to be
    assign beat_ready = (state == ST_IDLE) && resp_free && !done;
    assign take       = beat_valid && beat_ready;

    //////////////////////////////
    // Setup / access sequencer
    //////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state <= ST_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;   // Single-cycle strobe
            case (state)
                ST_IDLE:
                begin
                    if (take)
                    begin
                        if (beat.err)
                            done <= 1'b1;   // Bad address, skip the bus
                        else
                            state <= ST_SETUP;
                    end
                end
                ST_SETUP: state <= ST_ACCESS;
                ST_ACCESS:
                begin
                    if (pready)
                    begin
                        state <= ST_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (take)
            beat_q <= beat;
        if (take && beat.err)
            done_data <= '0;
        else if (state == ST_ACCESS && pready && !beat_q.req.write)
            done_data <= prdata;   // Read data sampled on PREADY
    end

    //////////////////////////////
    // APB drive
    //////////////////////////////

    assign apb_req   = beat_q.req;
    assign psel      = (state != ST_IDLE) ? beat_q.sel : '0;
    assign penable   = (state == ST_ACCESS);
    assign done_last = beat_q.last;
    assign done_err  = beat_q.err;

endmodule

// ==== source/apb_pkg.sv ====
`include "bridge_cfg.svh"

package apb_pkg;

    // Field view of a bridge address
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-`BRIDGE_REGION_LSB-1:0]     region;   // Must be zero
        logic [`BRIDGE_REGION_LSB-`BRIDGE_SEL_LSB-1:0]    sel;
        logic [`BRIDGE_SEL_LSB-1:0]                       offset;
    } apb_addr_view_t;

    // Same word, flat or split
    typedef union packed {
        logic [`BRIDGE_ADDR_W-1:0] flat;
        apb_addr_view_t            view;
    } apb_addr_u;

    // One-hot, bit n selects slave n
    typedef logic [`BRIDGE_NUM_SLAVES-1:0] apb_sel_t;

    typedef struct packed {
        apb_addr_u                 addr;
        logic                      write;
        logic [`BRIDGE_DATA_W-1:0] wdata;
    } apb_req_t;

    //////////////////////////////
    // Decode to execute handoff
    //////////////////////////////

    typedef struct packed {
        apb_req_t req;
        apb_sel_t sel;    // All zero on error
        logic     last;
        logic     err;
    } apb_beat_t;

endpackage

// ==== source/axi_apb_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module axi_apb_bridge
    import axi_pkg::*, apb_pkg::*;
(
    input  logic                      ACLK,
    input  logic                      ARESETn,
    // AXI side
    input  axi_addr_req_t             aw,
    input  logic                      aw_valid,
    output logic                      aw_ready,
    input  axi_addr_req_t             ar,
    input  logic                      ar_valid,
    output logic                      ar_ready,
    input  axi_w_beat_t               w,
    input  logic                      w_valid,
    output logic                      w_ready,
    output axi_r_beat_t               r,
    output logic                      r_valid,
    input  logic                      r_ready,
    output axi_resp_t                 b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    // APB side
    output apb_req_t                  apb_req,
    output apb_sel_t                  psel,
    output logic                      penable,
    input  logic [`BRIDGE_DATA_W-1:0] prdata,
    input  logic                      pready
);

    apb_beat_t                 beat;
    logic                      beat_valid;
    logic                      beat_ready;
    logic                      burst_done;
    logic                      resp_free;
    logic                      done;
    logic [`BRIDGE_DATA_W-1:0] done_data;
    logic                      done_last;
    logic                      done_err;

    //////////////////////////////
    // Decode stage
    //////////////////////////////

    axi_request_decode u_decode (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .aw         (aw),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .ar         (ar),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .w          (w),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .burst_done (burst_done)
    );

    //////////////////////////////
    // Execute stage
    //////////////////////////////

    apb_access_engine u_engine (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .resp_free  (resp_free),
        .apb_req    (apb_req),
        .psel       (psel),
        .penable    (penable),
        .prdata     (prdata),
        .pready     (pready),
        .done       (done),
        .done_data  (done_data),
        .done_last  (done_last),
        .done_err   (done_err)
    );

    // Write flag stays put until the next grant
    axi_response_path u_response (
        .ACLK       (ACLK),
        .ARESETn    (ARESETn),
        .is_write   (beat.req.write),
        .done       (done),
        .done_data  (done_data),
        .done_last  (done_last),
        .done_err   (done_err),
        .r          (r),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .b_resp     (b_resp),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .resp_free  (resp_free),
        .burst_done (burst_done)
    );

endmodule

// ==== source/axi_pkg.sv ====
`include "bridge_cfg.svh"

package axi_pkg;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01   // WRAP not supported
    } axi_burst_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    //////////////////////////////
    // Channel payloads
    //////////////////////////////

    // Shared by AW and AR
    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_LEN_W-1:0]  len;   // Beats minus one
        axi_burst_t                burst;
    } axi_addr_req_t;

    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0] data;
        logic                      last;
    } axi_w_beat_t;

    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0] data;
        axi_resp_t                 resp;
        logic                      last;
    } axi_r_beat_t;

endpackage

// ==== source/axi_request_decode.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module axi_request_decode
    import axi_pkg::*, apb_pkg::*;
(
    input  logic          ACLK,
    input  logic          ARESETn,
    input  axi_addr_req_t aw,
    input  logic          aw_valid,
    output logic          aw_ready,
    input  axi_addr_req_t ar,
    input  logic          ar_valid,
    output logic          ar_ready,
    input  axi_w_beat_t   w,
    input  logic          w_valid,
    output logic          w_ready,
    output apb_beat_t     beat,
    output logic          beat_valid,
    input  logic          beat_ready,
    input  logic          burst_done
);

    localparam logic [`BRIDGE_ADDR_W-1:0] ADDR_STEP = `BRIDGE_BEAT_BYTES;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,    // AW/AR ready
        ST_BEAT,    // Issuing beats
        ST_WAIT     // Last beat issued, wait for response
    } dec_state_t;

    dec_state_t               state;
    logic                     prio_write;
    logic                     is_write;
    logic                     grant_write;
    logic                     handoff;
    axi_addr_req_t            req_sel;
    apb_addr_u                cur_addr;
    axi_burst_t               cur_burst;
    logic [`BRIDGE_LEN_W-1:0] beats_left;
    logic                     addr_err;
    apb_sel_t                 sel_onehot;

    //////////////////////////////
    // Round-robin grant
    //////////////////////////////

    // Write wins a tie when the pointer says so
    assign grant_write = aw_valid && (!ar_valid || prio_write);

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            state      <= ST_IDLE;
            prio_write <= 1'b1;
            is_write   <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (aw_valid || ar_valid)
                    begin
                        is_write   <= grant_write;
                        prio_write <= !grant_write;   // Loser goes first next time
                        state      <= ST_ADDR;
                    end
                end
                ST_ADDR: state <= ST_BEAT;
                ST_BEAT:
                begin
                    if (handoff && beat.last)
                        state <= ST_WAIT;
                end
                ST_WAIT:
                begin
                    if (burst_done)
                        state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Burst capture and stepping
    //////////////////////////////

    assign req_sel = is_write ? aw : ar;

    always_ff @(posedge ACLK)
    begin
        if (state == ST_ADDR)
        begin
            cur_addr.flat <= req_sel.addr;
            cur_burst     <= req_sel.burst;
            beats_left    <= req_sel.len;
        end
        else if (handoff)
        begin
            beats_left <= beats_left - 1'b1;
            if (cur_burst == INCR)
                cur_addr.flat <= cur_addr.flat + ADDR_STEP;   // FIXED keeps address
        end
    end

    // Slave decode
    assign addr_err   = (cur_addr.view.region != '0);
    assign sel_onehot = apb_sel_t'(1) << cur_addr.view.sel;

    assign aw_ready   = (state == ST_ADDR) && is_write;
    assign ar_ready   = (state == ST_ADDR) && !is_write;
    assign beat_valid = (state == ST_BEAT) && (!is_write || w_valid);
    assign w_ready    = (state == ST_BEAT) && is_write && beat_ready;
    assign handoff    = beat_valid && beat_ready;

    // WLAST is not used, last beat comes from the count
    always_comb
    begin
        beat.req.addr  = cur_addr;
        beat.req.write = is_write;
        beat.req.wdata = is_write ? w.data : '0;
        beat.sel       = addr_err ? '0 : sel_onehot;
        beat.last      = (beats_left == '0);
        beat.err       = addr_err;
    end

endmodule

// ==== source/axi_response_path.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module axi_response_path
    import axi_pkg::*;
(
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  logic                      is_write,
    input  logic                      done,
    input  logic [`BRIDGE_DATA_W-1:0] done_data,
    input  logic                      done_last,
    input  logic                      done_err,
    output axi_r_beat_t               r,
    output logic                      r_valid,
    input  logic                      r_ready,
    output axi_resp_t                 b_resp,
    output logic                      b_valid,
    input  logic                      b_ready,
    output logic                      resp_free,
    output logic                      burst_done
);

    logic err_acc;   // Sticky error over the write burst
    logic rd_done;
    logic wr_done;

    assign rd_done = done && !is_write;
    assign wr_done = done && is_write;

    //////////////////////////////
    // Valid flags
    //////////////////////////////

    always_ff @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            r_valid <= 1'b0;
            b_valid <= 1'b0;
            err_acc <= 1'b0;
        end
        else
        begin
            if (r_valid && r_ready)
                r_valid <= 1'b0;
            if (b_valid && b_ready)
                b_valid <= 1'b0;
            if (rd_done)
                r_valid <= 1'b1;
            if (wr_done)
            begin
                if (done_last)
                begin
                    b_valid <= 1'b1;
                    err_acc <= 1'b0;   // Fresh for next burst
                end
                else
                    err_acc <= err_acc | done_err;
            end
        end
    end

    //////////////////////////////
    // Payload
    //////////////////////////////

    always_ff @(posedge ACLK)
    begin
        if (rd_done)
        begin
            r.data <= done_data;
            r.resp <= done_err ? SLVERR : OKAY;
            r.last <= done_last;
        end
        if (wr_done && done_last)
            b_resp <= (err_acc || done_err) ? SLVERR : OKAY;
    end

    // Nothing held, engine may start the next transfer
    assign resp_free = !r_valid && !b_valid;

    assign burst_done = (r_valid && r_ready && r.last) || (b_valid && b_ready);

endmodule

// ==== source/bridge_cfg.svh ====
`ifndef BRIDGE_CFG_SVH
`define BRIDGE_CFG_SVH

// Bus widths
`define BRIDGE_ADDR_W       32
`define BRIDGE_DATA_W       32
`define BRIDGE_LEN_W        8

// Four APB slaves behind the bridge
`define BRIDGE_NUM_SLAVES   4

// Address map, bits 9:8 pick the slave
`define BRIDGE_SEL_LSB      8
`define BRIDGE_REGION_LSB   10

// Word step for INCR bursts
`define BRIDGE_BEAT_BYTES   4

`endif

// ==== test/tb_apb_slave_model.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_apb_slave_model
    import apb_pkg::*;
(
    input  logic                      ACLK,
    input  logic                      ARESETn,
    input  apb_req_t                  req,
    input  apb_sel_t                  psel,
    input  logic                      penable,
    output logic [`BRIDGE_DATA_W-1:0] prdata,
    output logic                      pready,
    output logic                      sel_fault
);

    logic [`BRIDGE_DATA_W-1:0] mem [`BRIDGE_NUM_SLAVES][64];
    logic [31:0]               lfsr;
    logic [31:0]               lfsr_1;
    logic [31:0]               lfsr_2;
    logic [1:0]                wait_pick;
    logic [1:0]                wait_cnt;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
    endfunction

    // Fill pattern built from the full byte address
    initial
    begin
        for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++)
            for (int i = 0; i < 64; i++)
                mem[s][i] = 32'hc0de0000 ^ (s * 256 + i * 4);
    end

    // Two bits per wait count, one LFSR step each
    always_comb
    begin
        lfsr_1    = lfsr_next(lfsr);
        lfsr_2    = lfsr_next(lfsr_1);
        wait_pick = {lfsr_1[0], lfsr[0]};
    end

    always @(posedge ACLK or negedge ARESETn)
    begin
        if (!ARESETn)
        begin
            lfsr     <= 32'heed03c15;
            wait_cnt <= 2'd0;
        end
        else if (psel != '0 && !penable)
        begin
            wait_cnt <= wait_pick;   // Setup cycle
            lfsr     <= lfsr_2;
        end
        else if (psel != '0 && penable && wait_cnt != 2'd0)
            wait_cnt <= wait_cnt - 1'b1;
    end

    assign pready    = (psel != '0) && penable && (wait_cnt == 2'd0);
    assign prdata    = mem[req.addr.view.sel][req.addr.view.offset[7:2]];
    assign sel_fault = (psel & (psel - 1'b1)) != '0;   // More than one bit set

    always @(posedge ACLK)
    begin
        if (pready && req.write)
            mem[req.addr.view.sel][req.addr.view.offset[7:2]] <= req.wdata;
    end

endmodule

// ==== test/tb_axi_apb_bridge.sv ====
`timescale 1ns/1ps
`include "bridge_cfg.svh"

module tb_axi_apb_bridge
    import axi_pkg::*, apb_pkg::*;
;

    localparam int         TIMEOUT   = 200;
    localparam logic [1:0] OP_WR     = 2'd0;
    localparam logic [1:0] OP_RD     = 2'd1;
    localparam logic [1:0] OP_PAIR_W = 2'd2;   // AW and AR together, write wins
    localparam logic [1:0] OP_PAIR_R = 2'd3;   // AW and AR together, read wins

    typedef struct packed {
        logic [1:0]                op;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_LEN_W-1:0]  len;
        axi_burst_t                burst;
        logic [31:0]               seed;   // Write data base, low bits give stall
    } stim_t;

    logic                      ACLK;
    logic                      ARESETn;
    axi_addr_req_t             aw;
    logic                      aw_valid;
    logic                      aw_ready;
    axi_addr_req_t             ar;
    logic                      ar_valid;
    logic                      ar_ready;
    axi_w_beat_t               w;
    logic                      w_valid;
    logic                      w_ready;
    axi_r_beat_t               r;
    logic                      r_valid;
    logic                      r_ready;
    axi_resp_t                 b_resp;
    logic                      b_valid;
    logic                      b_ready;
    apb_req_t                  apb_req;
    apb_sel_t                  psel;
    logic                      penable;
    logic [`BRIDGE_DATA_W-1:0] prdata;
    logic                      pready;
    logic                      sel_fault;

    stim_t       stim [$];
    logic [31:0] shadow [`BRIDGE_NUM_SLAVES][64];
    realtime     aw_time;
    realtime     ar_time;
    logic [31:0] mon_addr;   // Next expected PADDR
    axi_burst_t  mon_burst;
    logic        mon_write;

    always #4 ACLK = ~ACLK;

    axi_apb_bridge DUT (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .aw       (aw),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .ar       (ar),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .w        (w),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .r        (r),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .b_resp   (b_resp),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .apb_req  (apb_req),
        .psel     (psel),
        .penable  (penable),
        .prdata   (prdata),
        .pready   (pready)
    );

    tb_apb_slave_model u_slave (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req       (apb_req),
        .psel      (psel),
        .penable   (penable),
        .prdata    (prdata),
        .pready    (pready),
        .sel_fault (sel_fault)
    );

    //////////////////////////////
    // Failure reporting
    //////////////////////////////

    task automatic end_in_failure();
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end_in_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        end_in_failure();
    endtask

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic in_range(input logic [31:0] a);
        return (a >> `BRIDGE_REGION_LSB) == '0;
    endfunction

    task automatic add_entry(input logic [1:0] op, input logic [31:0] addr,
                             input logic [7:0] len, input axi_burst_t burst,
                             input logic [31:0] seed);
        stim_t e;
        e.op    = op;
        e.addr  = addr;
        e.len   = len;
        e.burst = burst;
        e.seed  = seed;
        stim.push_back(e);
    endtask

    // Polls on the falling edge, where registered outputs are settled
    task automatic wait_for(input int which, input string name);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen)
        begin
            @(negedge ACLK);
            case (which)
                0: seen = aw_ready;
                1: seen = ar_ready;
                2: seen = w_ready;
                3: seen = r_valid;
                default: seen = b_valid;
            endcase
            n++;
            if (!seen && n >= TIMEOUT)
                report_problem({"Timed out waiting for ", name});
        end
    endtask

    // Hold RREADY or BREADY low, then take the response
    task automatic stall_response(input logic is_b, input int cycles);
        logic [63:0] snap;
        logic [63:0] cur;
        if (is_b)
            snap = b_resp;
        else
            snap = r;
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge ACLK);
            if (is_b)
                cur = b_resp;
            else
                cur = r;
            assert (is_b ? b_valid : r_valid)
                else report_value(is_b ? "BVALID" : "RVALID", 0, 1);
            assert (cur == snap) else report_value(is_b ? "BRESP" : "R", cur, snap);
            assert (psel == '0) else report_value("PSEL", psel, 0);
        end
        @(posedge ACLK);
        #1;
        if (is_b)
            b_ready = 1'b1;
        else
            r_ready = 1'b1;
        @(posedge ACLK);
        #1;
        b_ready = 1'b0;
        r_ready = 1'b0;
    endtask

    //////////////////////////////
    // Bursts
    //////////////////////////////

    task automatic run_write(input stim_t e);
        logic [31:0] a;
        logic        err;
        axi_resp_t   exp_b;
        a        = e.addr;
        err      = 1'b0;
        aw.addr  = e.addr;
        aw.len   = e.len;
        aw.burst = e.burst;
        aw_valid = 1'b1;
        wait_for(0, "AWREADY");
        @(posedge ACLK);
        #1;
        aw_valid  = 1'b0;
        aw_time   = $realtime;
        mon_addr  = e.addr;
        mon_burst = e.burst;
        mon_write = 1'b1;
        for (int k = 0; k <= e.len; k++)
        begin
            w.data  = e.seed + k;
            w.last  = (k == e.len);
            w_valid = 1'b1;
            wait_for(2, "WREADY");
            @(posedge ACLK);
            #1;
            w_valid = 1'b0;
            if (in_range(a))
                shadow[a[9:8]][a[7:2]] = e.seed + k;
            else
                err = 1'b1;
            if (e.burst == INCR)
                a = a + `BRIDGE_BEAT_BYTES;
        end
        wait_for(4, "BVALID");
        exp_b = err ? SLVERR : OKAY;
        assert (b_resp == exp_b) else report_value("BRESP", b_resp, exp_b);
        stall_response(1'b1, e.seed[2:0]);
    endtask

    task automatic run_read(input stim_t e);
        logic [31:0] a;
        logic [31:0] exp_d;
        a        = e.addr;
        ar.addr  = e.addr;
        ar.len   = e.len;
        ar.burst = e.burst;
        ar_valid = 1'b1;
        wait_for(1, "ARREADY");
        @(posedge ACLK);
        #1;
        ar_valid  = 1'b0;
        ar_time   = $realtime;
        mon_addr  = e.addr;
        mon_burst = e.burst;
        mon_write = 1'b0;
        for (int k = 0; k <= e.len; k++)
        begin
            wait_for(3, "RVALID");
            if (in_range(a))
            begin
                exp_d = shadow[a[9:8]][a[7:2]];
                assert (r.data == exp_d) else report_value("RDATA", r.data, exp_d);
                assert (r.resp == OKAY) else report_value("RRESP", r.resp, OKAY);
            end
            else
                assert (r.resp == SLVERR) else report_value("RRESP", r.resp, SLVERR);
            assert (r.last == (k == e.len)) else report_value("RLAST", r.last, k == e.len);
            stall_response(1'b0, e.seed[2:0]);
            if (e.burst == INCR)
                a = a + `BRIDGE_BEAT_BYTES;
        end
    endtask

    // Read goes one slave up from the write
    task automatic run_pair(input stim_t e, input logic write_first);
        stim_t e_rd;
        e_rd      = e;
        e_rd.addr = e.addr + 32'h100;
        fork
            run_write(e);
            run_read(e_rd);
        join
        if (write_first)
            assert (aw_time < ar_time) else report_problem("Read was granted before write");
        else
            assert (ar_time < aw_time) else report_problem("Write was granted before read");
    endtask

    //////////////////////////////
    // APB monitor
    //////////////////////////////

    always @(negedge ACLK)
    begin
        if (ARESETn)
        begin
            assert (!sel_fault) else report_problem("PSEL has more than one bit set");
            if (psel != '0 && !penable)   // Setup cycle
            begin
                // Out-of-range beats of an INCR burst use no APB cycle
                for (int j = 0; j < 256 && mon_burst == INCR && !in_range(mon_addr); j++)
                    mon_addr = mon_addr + `BRIDGE_BEAT_BYTES;
                assert (in_range(mon_addr))
                    else report_problem("PSEL raised for an out-of-range address");
                assert (psel == (apb_sel_t'(1) << mon_addr[`BRIDGE_SEL_LSB +: 2]))
                    else report_value("PSEL", psel, apb_sel_t'(1) << mon_addr[9:8]);
                assert (apb_req.write == mon_write)
                    else report_value("PWRITE", apb_req.write, mon_write);
                assert (apb_req.addr.flat == mon_addr)
                    else report_value("PADDR", apb_req.addr.flat, mon_addr);
                if (mon_burst == INCR)
                    mon_addr = mon_addr + `BRIDGE_BEAT_BYTES;
            end
        end
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        ACLK      = 1'b0;
        ARESETn   = 1'b0;
        aw        = '0;
        aw_valid  = 1'b0;
        ar        = '0;
        ar_valid  = 1'b0;
        w         = '0;
        w_valid   = 1'b0;
        r_ready   = 1'b0;
        b_ready   = 1'b0;
        mon_addr  = '0;
        mon_burst = FIXED;
        mon_write = 1'b0;
        for (int s = 0; s < `BRIDGE_NUM_SLAVES; s++)
            for (int i = 0; i < 64; i++)
                shadow[s][i] = 32'hc0de0000 ^ (s * 256 + i * 4);

        // Pair entries check the round-robin order
        add_entry(OP_PAIR_W, 32'h0000_0010, 8'd3, INCR,  32'h1111_0002);
        add_entry(OP_WR,     32'h0000_0200, 8'd3, INCR,  32'h2222_0005);
        add_entry(OP_PAIR_R, 32'h0000_0040, 8'd1, INCR,  32'h3333_0001);
        add_entry(OP_RD,     32'h0000_0200, 8'd3, INCR,  32'h0000_0004);
        add_entry(OP_WR,     32'h0000_03f0, 8'd2, FIXED, 32'h4444_0000);
        add_entry(OP_RD,     32'h0000_03f0, 8'd0, FIXED, 32'h0000_0006);
        add_entry(OP_WR,     32'h0000_1400, 8'd1, INCR,  32'h5555_0003);   // Out of range
        add_entry(OP_RD,     32'h8000_0100, 8'd2, FIXED, 32'h0000_0002);   // Out of range
        add_entry(OP_WR,     32'hffff_fffc, 8'd1, INCR,  32'h6666_0001);   // Bad, then wraps to 0
        add_entry(OP_RD,     32'h0000_00f8, 8'd3, INCR,  32'h0000_0007);   // Crosses slaves
        add_entry(OP_RD,     32'h0000_0010, 8'd3, INCR,  32'h0000_0000);

        repeat (16) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(negedge ACLK);
        assert ({aw_ready, ar_ready, w_ready, r_valid, b_valid, psel, penable} == '0)
            else report_problem("Ready, valid or APB select active after reset");
        @(posedge ACLK);
        #1;

        foreach (stim[i])
        begin
            case (stim[i].op)
                OP_WR:     run_write(stim[i]);
                OP_RD:     run_read(stim[i]);
                OP_PAIR_W: run_pair(stim[i], 1'b1);
                default:   run_pair(stim[i], 1'b0);
            endcase
        end

        $display("TEST PASS");
        $finish;
    end

endmodule
